// ==== rtl/xfcp_pkg.sv ====
// XFCP protocol definitions
// stream byte type and the two framing tags

`default_nettype none

package xfcp_pkg;

    // one byte on any XFCP stream
    typedef logic [7:0] xfcp_byte_t;

    // marks the start of the command body
    localparam xfcp_byte_t start_tag = 8'hff;

    // marks the return path, followed by the port address
    localparam xfcp_byte_t rpath_tag = 8'hfe;

endpackage

`default_nettype wire

// ==== rtl/switch_pkg.sv ====
// switch configuration
// upstream port count, port index type, request and response FSM states

`default_nettype none

package switch_pkg;

    localparam int num_ports = 2;

    typedef logic [$clog2(num_ports)-1:0] port_idx_t;

    // request direction, upstream to downstream
    typedef enum logic [2:0] {
        req_idle,
        req_header,
        req_insert_addr,
        req_insert_start,
        req_transfer
    } req_state_t;

    // response direction, downstream to upstream
    typedef enum logic [1:0] {
        resp_idle,
        resp_check_addr,
        resp_transfer,
        resp_drop
    } resp_state_t;

endpackage

`default_nettype wire

// ==== rtl/xfcp_skid_buffer.sv ====
// registered output stage for one XFCP stream
// output register plus temp register, ready toward the source is registered

`timescale 1ns/1ns
`default_nettype none

module xfcp_skid_buffer import xfcp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  xfcp_byte_t in_data,
    input  logic       in_valid,
    input  logic       in_last,
    input  logic       in_user,
    output logic       in_ready_early,
    output xfcp_byte_t out_data,
    output logic       out_valid,
    output logic       out_last,
    output logic       out_user,
    input  logic       out_ready
);

    logic       in_ready_reg;
    logic       out_valid_next;
    logic       temp_valid;
    logic       temp_valid_next;
    xfcp_byte_t temp_data;
    logic       temp_last;
    logic       temp_user;
    logic       store_in_to_out;
    logic       store_in_to_temp;
    logic       store_temp_to_out;

    // ready next cycle unless the temp register could fill up
    assign in_ready_early = out_ready | (~temp_valid & (~out_valid | ~in_valid));

    always_comb begin
        out_valid_next = out_valid;
        temp_valid_next = temp_valid;
        store_in_to_out = 1'b0;
        store_in_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready_reg) begin
            if (out_ready | ~out_valid) begin
                out_valid_next = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, park the byte
                temp_valid_next = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            out_valid_next = temp_valid;
            temp_valid_next = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            in_ready_reg <= 1'b0;
            out_valid <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            in_ready_reg <= in_ready_early;
            out_valid <= out_valid_next;
            temp_valid <= temp_valid_next;
        end
    end

    // payload moves
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_data <= in_data;
            out_last <= in_last;
            out_user <= in_user;
        end else if (store_temp_to_out) begin
            out_data <= temp_data;
            out_last <= temp_last;
            out_user <= temp_user;
        end

        if (store_in_to_temp) begin
            temp_data <= in_data;
            temp_last <= in_last;
            temp_user <= in_user;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xfcp_rr_arbiter.sv ====
// two-request round-robin arbiter
// grant stays locked until the granted port acknowledges its frame end

`timescale 1ns/1ns
`default_nettype none

module xfcp_rr_arbiter import switch_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [num_ports-1:0] request,
    input  logic [num_ports-1:0] acknowledge,
    output logic                 grant_valid,
    output port_idx_t            grant_port
);

    logic      grant_valid_next;
    port_idx_t grant_port_next;
    port_idx_t other_port;

    // grant_port keeps the last winner, so the search starts at the other one
    assign other_port = port_idx_t'(~grant_port);

    always_comb begin
        grant_valid_next = grant_valid;
        grant_port_next = grant_port;

        if (grant_valid) begin
            if (acknowledge[grant_port]) begin
                grant_valid_next = 1'b0;
            end
        end else if (request[other_port]) begin
            grant_valid_next = 1'b1;
            grant_port_next = other_port;
        end else if (request[grant_port]) begin
            grant_valid_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant_valid <= 1'b0;
            // port 1 as last winner puts port 0 first
            grant_port <= port_idx_t'(1);
        end else begin
            grant_valid <= grant_valid_next;
            grant_port <= grant_port_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/xfcp_request_path.sv ====
// request direction of the 2x1 switch
// upstream input mux, round-robin arbiter, route insertion FSM,
// registered skid stage toward the downstream port

`timescale 1ns/1ns
`default_nettype none

module xfcp_request_path import xfcp_pkg::*, switch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  xfcp_byte_t up_0_in_data,
    input  logic       up_0_in_valid,
    output logic       up_0_in_ready,
    input  logic       up_0_in_last,
    input  logic       up_0_in_user,
    input  xfcp_byte_t up_1_in_data,
    input  logic       up_1_in_valid,
    output logic       up_1_in_ready,
    input  logic       up_1_in_last,
    input  logic       up_1_in_user,
    output xfcp_byte_t down_out_data,
    output logic       down_out_valid,
    input  logic       down_out_ready,
    output logic       down_out_last,
    output logic       down_out_user
);

    req_state_t state, state_next;
    port_idx_t  sel, sel_next;
    logic       frame, frame_next;
    logic       need_start, need_start_next;
    logic       hold;
    logic       skid_ready, skid_ready_early;
    logic [num_ports-1:0] acknowledge;
    logic       grant_valid;
    port_idx_t  grant_port;
    xfcp_byte_t cur_data, skid_data;
    logic       cur_valid, cur_ready, cur_last, cur_user;
    logic       skid_valid, skid_last, skid_user;
    logic       take;

    assign acknowledge[0] = up_0_in_valid & up_0_in_ready & up_0_in_last;
    assign acknowledge[1] = up_1_in_valid & up_1_in_ready & up_1_in_last;

    xfcp_rr_arbiter arb_inst (
        .clk(clk), .rst(rst),
        .request({up_1_in_valid, up_0_in_valid}), .acknowledge(acknowledge),
        .grant_valid(grant_valid), .grant_port(grant_port)
    );

    // selected upstream port
    always_comb begin
        if (sel == port_idx_t'(1)) begin
            {cur_data, cur_valid, cur_ready} = {up_1_in_data, up_1_in_valid, up_1_in_ready};
            {cur_last, cur_user} = {up_1_in_last, up_1_in_user};
        end else begin
            {cur_data, cur_valid, cur_ready} = {up_0_in_data, up_0_in_valid, up_0_in_ready};
            {cur_last, cur_user} = {up_0_in_last, up_0_in_user};
        end
    end

    assign take = cur_valid & cur_ready;

    always_comb begin
        state_next = state;
        sel_next = sel;
        frame_next = frame;
        need_start_next = need_start;
        hold = 1'b0;
        skid_data = cur_data;
        skid_valid = take & frame;
        skid_last = cur_last;
        skid_user = cur_user;

        if (take & cur_last) begin
            frame_next = 1'b0;
        end

        case (state)
            req_idle: begin
                if (grant_valid & skid_ready) begin
                    frame_next = 1'b1;
                    sel_next = grant_port;
                    state_next = req_header;
                end
            end
            req_header: begin
                if (take) begin
                    if (cur_last) begin
                        // no tag in the frame
                        skid_user = 1'b1;
                        state_next = req_idle;
                    end else if (cur_data == rpath_tag) begin
                        hold = 1'b1;
                        need_start_next = 1'b0;
                        state_next = req_insert_addr;
                    end else if (cur_data == start_tag) begin
                        // start goes out as rpath, start follows the address
                        skid_data = rpath_tag;
                        hold = 1'b1;
                        need_start_next = 1'b1;
                        state_next = req_insert_addr;
                    end
                end
            end
            req_insert_addr, req_insert_start: begin
                hold = 1'b1;
                if (skid_ready) begin
                    skid_data = (state == req_insert_addr) ? xfcp_byte_t'(sel) : start_tag;
                    skid_valid = 1'b1;
                    skid_last = 1'b0;
                    skid_user = 1'b0;
                    if (state == req_insert_addr && need_start) begin
                        state_next = req_insert_start;
                    end else begin
                        hold = 1'b0;
                        state_next = req_transfer;
                    end
                end
            end
            req_transfer: begin
                if (take & cur_last) begin
                    state_next = req_idle;
                end
            end
            default: state_next = req_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= req_idle;
            sel <= port_idx_t'(0);
            frame <= 1'b0;
            need_start <= 1'b0;
            skid_ready <= 1'b0;
            up_0_in_ready <= 1'b0;
            up_1_in_ready <= 1'b0;
        end else begin
            state <= state_next;
            sel <= sel_next;
            frame <= frame_next;
            need_start <= need_start_next;
            skid_ready <= skid_ready_early;
            up_0_in_ready <= (sel_next == port_idx_t'(0)) & skid_ready_early & frame_next & ~hold;
            up_1_in_ready <= (sel_next == port_idx_t'(1)) & skid_ready_early & frame_next & ~hold;
        end
    end

    xfcp_skid_buffer down_skid (
        .clk(clk), .rst(rst),
        .in_data(skid_data), .in_valid(skid_valid), .in_last(skid_last),
        .in_user(skid_user), .in_ready_early(skid_ready_early),
        .out_data(down_out_data), .out_valid(down_out_valid), .out_last(down_out_last),
        .out_user(down_out_user), .out_ready(down_out_ready)
    );

endmodule

`default_nettype wire

// ==== rtl/xfcp_response_path.sv ====
// response direction of the 2x1 switch
// route check and strip FSM, shared skid stage, valid fan-out per upstream port

`timescale 1ns/1ns
`default_nettype none

module xfcp_response_path import xfcp_pkg::*, switch_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  xfcp_byte_t down_in_data,
    input  logic       down_in_valid,
    output logic       down_in_ready,
    input  logic       down_in_last,
    input  logic       down_in_user,
    output xfcp_byte_t up_0_out_data,
    output logic       up_0_out_valid,
    input  logic       up_0_out_ready,
    output logic       up_0_out_last,
    output logic       up_0_out_user,
    output xfcp_byte_t up_1_out_data,
    output logic       up_1_out_valid,
    input  logic       up_1_out_ready,
    output logic       up_1_out_last,
    output logic       up_1_out_user
);

    resp_state_t state, state_next;
    port_idx_t   route, route_next;
    logic        ready_next;
    logic        take;
    logic        skid_valid, skid_ready_early;
    xfcp_byte_t  out_data;
    logic        out_valid, out_ready, out_last, out_user;

    assign take = down_in_valid & down_in_ready;
    // only the payload after the route reaches the skid stage
    assign skid_valid = take & (state == resp_transfer);

    always_comb begin
        state_next = state;
        route_next = route;
        ready_next = 1'b0;

        case (state)
            resp_idle: begin
                // previous frame must have left the output first
                ready_next = ~out_valid;
                if (take && !down_in_last) begin
                    ready_next = 1'b1;
                    state_next = (down_in_data == rpath_tag) ? resp_check_addr : resp_drop;
                end
            end
            resp_check_addr: begin
                ready_next = 1'b1;
                if (take) begin
                    if (down_in_last) begin
                        ready_next = 1'b0;
                        state_next = resp_idle;
                    end else if (down_in_data < xfcp_byte_t'(num_ports)) begin
                        route_next = down_in_data[0];
                        ready_next = skid_ready_early;
                        state_next = resp_transfer;
                    end else begin
                        state_next = resp_drop;
                    end
                end
            end
            resp_transfer: begin
                ready_next = skid_ready_early;
                if (take & down_in_last) begin
                    ready_next = 1'b0;
                    state_next = resp_idle;
                end
            end
            resp_drop: begin
                ready_next = 1'b1;
                if (take & down_in_last) begin
                    ready_next = 1'b0;
                    state_next = resp_idle;
                end
            end
            default: state_next = resp_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= resp_idle;
            route <= port_idx_t'(0);
            down_in_ready <= 1'b0;
        end else begin
            state <= state_next;
            route <= route_next;
            down_in_ready <= ready_next;
        end
    end

    xfcp_skid_buffer up_skid (
        .clk(clk), .rst(rst),
        .in_data(down_in_data), .in_valid(skid_valid), .in_last(down_in_last),
        .in_user(down_in_user), .in_ready_early(skid_ready_early),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .out_user(out_user), .out_ready(out_ready)
    );

    // route picks the port that sees valid and returns ready
    assign out_ready = (route == port_idx_t'(1)) ? up_1_out_ready : up_0_out_ready;
    assign up_0_out_valid = out_valid & (route == port_idx_t'(0));
    assign up_1_out_valid = out_valid & (route == port_idx_t'(1));

    assign up_0_out_data = out_data;
    assign up_0_out_last = out_last;
    assign up_0_out_user = out_user;
    assign up_1_out_data = out_data;
    assign up_1_out_last = out_last;
    assign up_1_out_user = out_user;

endmodule

`default_nettype wire

// ==== rtl/xfcp_switch_2x1.sv ====
// XFCP 2x1 switch top level
// request path from two upstream ports, response path back to them

`timescale 1ns/1ns
`default_nettype none

module xfcp_switch_2x1 import xfcp_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  xfcp_byte_t up_0_in_data,
    input  logic       up_0_in_valid,
    output logic       up_0_in_ready,
    input  logic       up_0_in_last,
    input  logic       up_0_in_user,
    output xfcp_byte_t up_0_out_data,
    output logic       up_0_out_valid,
    input  logic       up_0_out_ready,
    output logic       up_0_out_last,
    output logic       up_0_out_user,
    input  xfcp_byte_t up_1_in_data,
    input  logic       up_1_in_valid,
    output logic       up_1_in_ready,
    input  logic       up_1_in_last,
    input  logic       up_1_in_user,
    output xfcp_byte_t up_1_out_data,
    output logic       up_1_out_valid,
    input  logic       up_1_out_ready,
    output logic       up_1_out_last,
    output logic       up_1_out_user,
    input  xfcp_byte_t down_in_data,
    input  logic       down_in_valid,
    output logic       down_in_ready,
    input  logic       down_in_last,
    input  logic       down_in_user,
    output xfcp_byte_t down_out_data,
    output logic       down_out_valid,
    input  logic       down_out_ready,
    output logic       down_out_last,
    output logic       down_out_user
);

    xfcp_request_path req_path (
        .clk(clk), .rst(rst),
        .up_0_in_data(up_0_in_data), .up_0_in_valid(up_0_in_valid),
        .up_0_in_ready(up_0_in_ready), .up_0_in_last(up_0_in_last),
        .up_0_in_user(up_0_in_user),
        .up_1_in_data(up_1_in_data), .up_1_in_valid(up_1_in_valid),
        .up_1_in_ready(up_1_in_ready), .up_1_in_last(up_1_in_last),
        .up_1_in_user(up_1_in_user),
        .down_out_data(down_out_data), .down_out_valid(down_out_valid),
        .down_out_ready(down_out_ready), .down_out_last(down_out_last),
        .down_out_user(down_out_user)
    );

    xfcp_response_path resp_path (
        .clk(clk), .rst(rst),
        .down_in_data(down_in_data), .down_in_valid(down_in_valid),
        .down_in_ready(down_in_ready), .down_in_last(down_in_last),
        .down_in_user(down_in_user),
        .up_0_out_data(up_0_out_data), .up_0_out_valid(up_0_out_valid),
        .up_0_out_ready(up_0_out_ready), .up_0_out_last(up_0_out_last),
        .up_0_out_user(up_0_out_user),
        .up_1_out_data(up_1_out_data), .up_1_out_valid(up_1_out_valid),
        .up_1_out_ready(up_1_out_ready), .up_1_out_last(up_1_out_last),
        .up_1_out_user(up_1_out_user)
    );

endmodule

`default_nettype wire

// ==== verif/tb_xfcp_switch.sv ====
// testbench for the XFCP 2x1 switch
// vector file reader, stream drivers, output monitors with random back-pressure,
// compare tasks, one report line per test and a closing summary

`timescale 1ns/1ns
`default_nettype none

module tb_xfcp_switch import xfcp_pkg::*, switch_pkg::*; ();

    localparam int batch_limit = 4000;
    localparam int drain_cycles = 24;

    logic clk = 1'b0;
    logic rst = 1'b1;

    // driver slot 0 is up_0_in, 1 is up_1_in and 2 is down_in
    // bit 8 of a driver word carries last
    logic [2:0] drv_valid = '0;
    logic [8:0] drv_word [3] = '{default: '0};
    logic [2:0] taken = '0;
    wire  [2:0] src_ready;
    logic [8:0] send_q [3][$];

    // monitor slot 0 is down_out, 1 is up_0_out and 2 is up_1_out
    logic [2:0] sink_ready = '0;
    wire  [2:0] sink_valid;
    wire  [2:0] sink_last;
    wire  [2:0] sink_user;
    wire  [7:0] sink_data [3];
    int         mon_pos [3] = '{default: 0};
    // queue 0 holds downstream test numbers and queue 1 the upstream ones
    int         expect_q [2][$];

    string       names[$];
    int          dst_port[$];
    int          out_len[$];
    logic [63:0] out_bytes[$];
    logic        out_user[$];
    int          test_errs[$];
    int          n_pass = 0;
    int          n_fail = 0;
    int          other_errs = 0;
    logic        timed_out = 1'b0;

    always #4 clk = ~clk;

    xfcp_switch_2x1 uut (
        .clk(clk), .rst(rst),
        .up_0_in_data(drv_word[0][7:0]), .up_0_in_valid(drv_valid[0]),
        .up_0_in_ready(src_ready[0]), .up_0_in_last(drv_word[0][8]), .up_0_in_user(1'b0),
        .up_0_out_data(sink_data[1]), .up_0_out_valid(sink_valid[1]),
        .up_0_out_ready(sink_ready[1]), .up_0_out_last(sink_last[1]),
        .up_0_out_user(sink_user[1]),
        .up_1_in_data(drv_word[1][7:0]), .up_1_in_valid(drv_valid[1]),
        .up_1_in_ready(src_ready[1]), .up_1_in_last(drv_word[1][8]), .up_1_in_user(1'b0),
        .up_1_out_data(sink_data[2]), .up_1_out_valid(sink_valid[2]),
        .up_1_out_ready(sink_ready[2]), .up_1_out_last(sink_last[2]),
        .up_1_out_user(sink_user[2]),
        .down_in_data(drv_word[2][7:0]), .down_in_valid(drv_valid[2]),
        .down_in_ready(src_ready[2]), .down_in_last(drv_word[2][8]), .down_in_user(1'b0),
        .down_out_data(sink_data[0]), .down_out_valid(sink_valid[0]),
        .down_out_ready(sink_ready[0]), .down_out_last(sink_last[0]),
        .down_out_user(sink_user[0])
    );

    // new words and a fresh ready pattern shortly after each rising edge
    always @(posedge clk) begin
        #1;
        for (int p = 0; p < 3; p++) begin
            if (!drv_valid[p] || taken[p]) begin
                if (send_q[p].size() > 0) begin
                    drv_word[p] = send_q[p].pop_front();
                    drv_valid[p] = 1'b1;
                end else begin
                    drv_valid[p] = 1'b0;
                end
            end
        end
        for (int o = 0; o < 3; o++) begin
            sink_ready[o] = ($urandom % 4) != 0;
        end
    end

    // handshakes seen here complete on the next rising edge
    always @(negedge clk) begin
        taken = drv_valid & src_ready;
        for (int o = 0; o < 3; o++) begin
            if (!rst && sink_valid[o] && sink_ready[o]) begin
                take_output_byte(o);
            end
        end
    end

    task automatic check_byte(input int t, input string what, input xfcp_byte_t exp,
                              input xfcp_byte_t act);
        if (exp !== act) begin
            $display("error %s %s: expected %h, actual %h", names[t], what, exp, act);
            test_errs[t] = test_errs[t] + 1;
        end
    endtask

    task automatic check_port(input int t, input port_idx_t exp, input port_idx_t act);
        if (exp !== act) begin
            $display("error %s port: expected %0d, actual %0d", names[t], exp, act);
            test_errs[t] = test_errs[t] + 1;
        end
    endtask

    task automatic check_flag(input int t, input string what, input logic exp,
                              input logic act);
        if (exp !== act) begin
            $display("error %s %s: expected %b, actual %b", names[t], what, exp, act);
            test_errs[t] = test_errs[t] + 1;
        end
    endtask

    task automatic report_test(input int t);
        if (test_errs[t] == 0) begin
            $display("pass %s", names[t]);
            n_pass++;
        end else begin
            $display("fail %s with %0d errors", names[t], test_errs[t]);
            n_fail++;
        end
    endtask

    task automatic queue_frame(input int p, input logic [63:0] w, input int n);
        // first byte sits in the leftmost hex digits
        for (int i = 0; i < n; i++) begin
            send_q[p].push_back({i == n - 1, w[8*(n-1-i) +: 8]});
        end
    endtask

    task automatic take_output_byte(input int o);
        int q;
        int t;
        int i;
        logic [63:0] w;
        logic at_end;
        q = (o == 0) ? 0 : 1;
        i = mon_pos[o];
        if (expect_q[q].size() == 0) begin
            if (i == 0) begin
                $display("unexpected frame appeared on output %0d", o);
                other_errs++;
            end
            mon_pos[o] = sink_last[o] ? 0 : i + 1;
            return;
        end
        t = expect_q[q][0];
        w = out_bytes[t];
        at_end = (i == out_len[t] - 1);
        if (o != 0 && i == 0) begin
            check_port(t, port_idx_t'(dst_port[t]), port_idx_t'(o - 1));
        end
        if (i < out_len[t]) begin
            check_byte(t, $sformatf("byte %0d", i), w[8*(out_len[t]-1-i) +: 8], sink_data[o]);
        end else begin
            $display("%s: output frame runs past %0d bytes", names[t], out_len[t]);
            test_errs[t] = test_errs[t] + 1;
        end
        check_flag(t, $sformatf("last at byte %0d", i), at_end, sink_last[o]);
        check_flag(t, $sformatf("user at byte %0d", i), at_end & out_user[t], sink_user[o]);
        if (sink_last[o]) begin
            t = expect_q[q].pop_front();
            mon_pos[o] = 0;
            report_test(t);
        end else begin
            mon_pos[o] = i + 1;
        end
    endtask

    function automatic logic batch_done();
        return drv_valid == 3'b000 && send_q[0].size() == 0 && send_q[1].size() == 0
            && send_q[2].size() == 0 && expect_q[0].size() == 0 && expect_q[1].size() == 0;
    endfunction

    task automatic finish_batch(input int t, input int errs_before);
        int cycles;
        cycles = 0;
        while (!batch_done() && cycles < batch_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!batch_done()) begin
            $display("timeout: test %s still had bytes in flight after %0d cycles",
                     names[t], batch_limit);
            other_errs++;
            timed_out = 1'b1;
        end else begin
            // quiet period so late or stray bytes still show up
            for (int i = 0; i < drain_cycles; i++) begin
                @(negedge clk);
            end
            for (int o = 0; o < 3; o++) begin
                if (mon_pos[o] != 0) begin
                    $display("output %0d stopped in the middle of a frame", o);
                    other_errs++;
                    mon_pos[o] = 0;
                end
            end
            // dropped frames pass when nothing came out
            if (out_len[t] == 0) begin
                test_errs[t] = test_errs[t] + (other_errs - errs_before);
                report_test(t);
            end
        end
    endtask

    initial begin
        int fd;
        int code;
        int c;
        int src;
        int n_in;
        int dst;
        int n_out;
        int user;
        int hold_on;
        int t;
        int errs_before;
        string tok;
        string dir;
        logic [63:0] in_w;
        logic [63:0] out_w;

        void'($urandom(32'hc448d239));
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);

        fd = $fopen("verif/switch_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/switch_vectors.txt");
            other_errs++;
        end else begin
            errs_before = 0;
            while (!timed_out) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    break;
                end
                if (tok.getc(0) == "#") begin
                    c = 0;
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                    continue;
                end
                code = $fscanf(fd, "%s %d %d %h %d %d %h %d %d", dir, src, n_in, in_w, dst,
                               n_out, out_w, user, hold_on);
                if (code != 9) begin
                    $display("vector record %s is incomplete", tok);
                    other_errs++;
                    break;
                end
                t = names.size();
                names.push_back(tok);
                dst_port.push_back(dst);
                out_len.push_back(n_out);
                out_bytes.push_back(out_w);
                out_user.push_back(user != 0);
                test_errs.push_back(0);
                queue_frame((dir == "resp") ? 2 : src, in_w, n_in);
                if (n_out > 0) begin
                    expect_q[(dir == "resp") ? 1 : 0].push_back(t);
                end
                // hold_on 0 lets the next record start in the same cycle
                if (hold_on != 0) begin
                    finish_batch(t, errs_before);
                    errs_before = other_errs;
                end
            end
            $fclose(fd);
        end

        $display("tests %0d, passed %0d, failed %0d, other errors %0d",
                 names.size(), n_pass, n_fail, other_errs);
        if (names.size() > 0 && n_pass == names.size() && n_fail == 0 && other_errs == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/switch_vectors.txt ====
# name dir src n_in in_bytes dst n_out out_bytes last_user hold_on
# req enters at up port src and leaves downstream; resp enters downstream; n_out 0 = dropped
start_port1      req  1 5 0102ff1011 0 7 0102fe01ff1011 0 1
rpath_port0      req  0 5 03fe202122 0 6 03fe00202122   0 1
no_tag_port1     req  1 3 050607     0 3 050607         1 1
pair_port0       req  0 3 fe3031     0 4 fe003031       0 0
pair_port1       req  1 3 ff4041     0 5 fe01ff4041     0 1
start_first      req  0 3 ff1213     0 5 fe00ff1213     0 1
no_tag_single    req  0 1 aa         0 1 aa             1 1
resp_port1       resp 0 5 fe01505152 1 3 505152         0 1
resp_bad_addr    resp 0 4 fe056061   0 0 0              0 1
resp_no_rpath    resp 0 3 700171     0 0 0              0 1
resp_port0_after resp 0 4 fe008081   0 2 8081           0 1
resp_port1_one   resp 0 3 fe0199     1 1 99             0 1

// ==== project.f ====
rtl/xfcp_pkg.sv
rtl/switch_pkg.sv
rtl/xfcp_skid_buffer.sv
rtl/xfcp_rr_arbiter.sv
rtl/xfcp_request_path.sv
rtl/xfcp_response_path.sv
rtl/xfcp_switch_2x1.sv
verif/tb_xfcp_switch.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the switch testbench with Verilator, run it, then look for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/1ns --top-module tb_xfcp_switch -f project.f \
    -o tb_xfcp_switch > sim.log 2>&1 \
    && ./obj_dir/tb_xfcp_switch >> sim.log 2>&1 \
    || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -qx "Simulation passed" sim.log || exit 1
exit 0
